// File: vlog.f
ifm_buffer_pkg.sv
ifm_group_if.sv
ifm_map_ram.sv
ifm_group.sv
ifm_bank_router.sv
ifm_bank.sv
tb_ifm_bank.sv

// File: tb_ifm_bank.sv
module tb_ifm_bank
	import ifm_buffer_pkg::*;
();

	localparam int NUM_MAPS = 16;
	localparam int BURST = 16;
	localparam int MAX_CYCLES = 5000;

	logic clk;
	logic rst_n;
	sel_t ifm_sel;
	logic en_wr;
	logic en_rd_prev;
	logic en_rd_a;
	logic en_rd_b;
	addr_t addr_wr;
	addr_t addr_rd_prev;
	addr_t addr_rd_a;
	addr_t addr_rd_b;
	lane_data_t data_in;

	data_t out_prev1;
	data_t out_prev2;
	data_t out_prev3;
	data_t out_a1;
	data_t out_a2;
	data_t out_a3;
	data_t out_b1;
	data_t out_b2;
	data_t out_b3;
	lane_data_t out_prev;
	lane_data_t out_a;
	lane_data_t out_b;

	// Reference model of the stored maps and of every group's read registers.
	data_t model_mem [NUM_MAPS][MAP_DEPTH];
	bit written [NUM_MAPS][MAP_DEPTH];
	lane_data_t reg_a [NUM_GROUPS];
	lane_data_t reg_b [NUM_GROUPS];
	addr_t wr_list [NUM_GROUPS][MAP_DEPTH];
	int wr_count [NUM_GROUPS];

	integer seed;
	int errors;
	int checks;

	assign out_prev = {out_prev3, out_prev2, out_prev1};
	assign out_a = {out_a3, out_a2, out_a1};
	assign out_b = {out_b3, out_b2, out_b1};

	ifm_bank UUT
	(
		.clk(clk),
		.rst_n(rst_n),
		.ifm_sel(ifm_sel),
		.ifm_enable_write_previous(en_wr),
		.ifm_enable_read_previous(en_rd_prev),
		.ifm_address_write_previous(addr_wr),
		.ifm_address_read_previous(addr_rd_prev),
		.data_in_from_previous1(data_in[0]),
		.data_in_from_previous2(data_in[1]),
		.data_in_from_previous3(data_in[2]),
		.data_out_for_previous1(out_prev1),
		.data_out_for_previous2(out_prev2),
		.data_out_for_previous3(out_prev3),
		.ifm_enable_read_a_next(en_rd_a),
		.ifm_enable_read_b_next(en_rd_b),
		.ifm_address_read_a_next(addr_rd_a),
		.ifm_address_read_b_next(addr_rd_b),
		.data_out_a_for_next1(out_a1),
		.data_out_a_for_next2(out_a2),
		.data_out_a_for_next3(out_a3),
		.data_out_b_for_next1(out_b1),
		.data_out_b_for_next2(out_b2),
		.data_out_b_for_next3(out_b3)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Codes 6 and 7 act on the last group.
	function automatic int clamp_sel(sel_t s);
		if (s > LAST_GROUP)
		begin
			return LAST_GROUP;
		end
		return int'(s);
	endfunction

	function automatic int reader_of(int w);
		return (w == 0) ? LAST_GROUP : w - 1;
	endfunction

	function automatic int group_maps(int g);
		return (g == LAST_GROUP) ? 1 : NUM_LANES;
	endfunction

	function automatic int map_index(int g, int k);
		return g * NUM_LANES + k;
	endfunction

	function automatic logic rand_bit();
		return logic'($random(seed) & 1);
	endfunction

	function automatic addr_t rand_addr();
		return addr_t'($random(seed));
	endfunction

	function automatic lane_data_t rand_lanes();
		lane_data_t lanes;
		for (int k = 0; k < NUM_LANES; k++)
		begin
			lanes[k] = data_t'($random(seed));
		end
		return lanes;
	endfunction

	function automatic addr_t pick_addr(int g);
		return wr_list[g][$unsigned($random(seed)) % wr_count[g]];
	endfunction

	task automatic check_word(string name, data_t got, data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_lanes(string name, lane_data_t got, lane_data_t exp);
		for (int k = 0; k < NUM_LANES; k++)
		begin
			check_word($sformatf("%s%0d", name, k + 1), got[k], exp[k]);
		end
	endtask

	// Reads see the contents from before the edge, so they are taken before the write.
	task automatic update_model();
		int w;
		int r;
		w = clamp_sel(ifm_sel);
		r = reader_of(w);
		for (int k = 0; k < group_maps(w); k++)
		begin
			if (en_rd_prev)
			begin
				reg_b[w][k] = model_mem[map_index(w, k)][addr_rd_prev];
			end
		end
		for (int k = 0; k < group_maps(r); k++)
		begin
			if (en_rd_a)
			begin
				reg_a[r][k] = model_mem[map_index(r, k)][addr_rd_a];
			end
			if (en_rd_b)
			begin
				reg_b[r][k] = model_mem[map_index(r, k)][addr_rd_b];
			end
		end
		if (en_wr)
		begin
			if (!written[map_index(w, 0)][addr_wr])
			begin
				wr_list[w][wr_count[w]] = addr_wr;
				wr_count[w]++;
			end
			for (int k = 0; k < group_maps(w); k++)
			begin
				model_mem[map_index(w, k)][addr_wr] = data_in[k];
				written[map_index(w, k)][addr_wr] = 1'b1;
			end
		end
	endtask

	task automatic compare_outputs();
		int w;
		int r;
		w = clamp_sel(ifm_sel);
		r = reader_of(w);
		check_lanes("data_out_for_previous", out_prev, reg_b[w]);
		check_lanes("data_out_a_for_next", out_a, reg_a[r]);
		check_lanes("data_out_b_for_next", out_b, reg_b[r]);
	endtask

	// Inputs were set on the falling edge; outputs are compared on the next one.
	task automatic run_cycle();
		@(posedge clk);
		update_model();
		@(negedge clk);
		compare_outputs();
	endtask

	task automatic go_idle();
		en_wr = 1'b0;
		en_rd_prev = 1'b0;
		en_rd_a = 1'b0;
		en_rd_b = 1'b0;
	endtask

	task automatic select_group(sel_t s);
		go_idle();
		ifm_sel = s;
		run_cycle();
	endtask

	task automatic random_cycle();
		int w;
		int r;
		w = clamp_sel(ifm_sel);
		r = reader_of(w);
		go_idle();
		en_wr = rand_bit();
		addr_wr = rand_addr();
		data_in = rand_lanes();
		if (wr_count[w] > 0)
		begin
			en_rd_prev = rand_bit();
			addr_rd_prev = pick_addr(w);
		end
		if (wr_count[r] > 0)
		begin
			en_rd_a = rand_bit();
			en_rd_b = rand_bit();
			addr_rd_a = pick_addr(r);
			addr_rd_b = pick_addr(r);
		end
		run_cycle();
	endtask

	initial
	begin
		for (int n = 0; n < MAX_CYCLES; n++)
		begin
			@(posedge clk);
		end
		$display("Timeout: the run did not end within %0d clock cycles", MAX_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		seed = 32'h6954;
		errors = 0;
		checks = 0;
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			reg_a[g] = '0;
			reg_b[g] = '0;
			wr_count[g] = 0;
		end
		rst_n = 1'b0;
		ifm_sel = '0;
		go_idle();
		addr_wr = '0;
		addr_rd_prev = '0;
		addr_rd_a = '0;
		addr_rd_b = '0;
		data_in = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		compare_outputs();

		// Fill every group, then read it back through the previous layer's port B.
		for (int s = 0; s < NUM_GROUPS; s++)
		begin
			select_group(sel_t'(s));
			for (int i = 0; i < BURST; i++)
			begin
				go_idle();
				en_wr = 1'b1;
				addr_wr = rand_addr();
				data_in = rand_lanes();
				run_cycle();
			end
			for (int i = 0; i < BURST; i++)
			begin
				go_idle();
				en_rd_prev = 1'b1;
				addr_rd_prev = pick_addr(s);
				run_cycle();
			end
		end

		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			select_group(sel_t'((g + 1) % NUM_GROUPS));
			for (int i = 0; i < BURST; i++)
			begin
				go_idle();
				en_rd_a = rand_bit();
				en_rd_b = rand_bit();
				addr_rd_a = pick_addr(g);
				addr_rd_b = pick_addr(g);
				run_cycle();
			end
		end

		for (int i = 0; i < 300; i++)
		begin
			if ($unsigned($random(seed)) % 10 == 0)
			begin
				select_group(sel_t'($unsigned($random(seed)) % NUM_GROUPS));
			end
			else
			begin
				random_cycle();
			end
		end

		// Out-of-range selector codes.
		select_group(sel_t'(6));
		repeat (30) random_cycle();
		select_group(sel_t'(7));
		repeat (30) random_cycle();

		// With every enable low the read registers must hold.
		for (int i = 0; i < 20; i++)
		begin
			go_idle();
			addr_wr = rand_addr();
			addr_rd_prev = rand_addr();
			addr_rd_a = rand_addr();
			addr_rd_b = rand_addr();
			data_in = rand_lanes();
			run_cycle();
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: ifm_bank.sv
module ifm_bank
	import ifm_buffer_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input sel_t ifm_sel,

	input logic ifm_enable_write_previous,
	input logic ifm_enable_read_previous,
	input addr_t ifm_address_write_previous,
	input addr_t ifm_address_read_previous,
	input data_t data_in_from_previous1,
	input data_t data_in_from_previous2,
	input data_t data_in_from_previous3,
	output data_t data_out_for_previous1,
	output data_t data_out_for_previous2,
	output data_t data_out_for_previous3,

	input logic ifm_enable_read_a_next,
	input logic ifm_enable_read_b_next,
	input addr_t ifm_address_read_a_next,
	input addr_t ifm_address_read_b_next,
	output data_t data_out_a_for_next1,
	output data_t data_out_a_for_next2,
	output data_t data_out_a_for_next3,
	output data_t data_out_b_for_next1,
	output data_t data_out_b_for_next2,
	output data_t data_out_b_for_next3
);

	lane_data_t data_in_previous;
	lane_data_t data_out_previous;
	lane_data_t data_out_a_next;
	lane_data_t data_out_b_next;

	ifm_group_if grp_if [NUM_GROUPS] ();

	assign data_in_previous[0] = data_in_from_previous1;
	assign data_in_previous[1] = data_in_from_previous2;
	assign data_in_previous[2] = data_in_from_previous3;

	assign data_out_for_previous1 = data_out_previous[0];
	assign data_out_for_previous2 = data_out_previous[1];
	assign data_out_for_previous3 = data_out_previous[2];

	assign data_out_a_for_next1 = data_out_a_next[0];
	assign data_out_a_for_next2 = data_out_a_next[1];
	assign data_out_a_for_next3 = data_out_a_next[2];

	assign data_out_b_for_next1 = data_out_b_next[0];
	assign data_out_b_for_next2 = data_out_b_next[1];
	assign data_out_b_for_next3 = data_out_b_next[2];

	ifm_bank_router u_router
	(
		.ifm_sel(ifm_sel),
		.enable_write_previous(ifm_enable_write_previous),
		.enable_read_previous(ifm_enable_read_previous),
		.enable_read_a_next(ifm_enable_read_a_next),
		.enable_read_b_next(ifm_enable_read_b_next),
		.address_write_previous(ifm_address_write_previous),
		.address_read_previous(ifm_address_read_previous),
		.address_read_a_next(ifm_address_read_a_next),
		.address_read_b_next(ifm_address_read_b_next),
		.data_in_previous(data_in_previous),
		.data_out_previous(data_out_previous),
		.data_out_a_next(data_out_a_next),
		.data_out_b_next(data_out_b_next),
		.groups(grp_if)
	);

	genvar g;

	generate
		for (g = 0; g < LAST_GROUP; g++)
		begin : g_full
			ifm_group #(
				.num_maps(NUM_LANES)
			) u_group
			(
				.clk(clk),
				.rst_n(rst_n),
				.port(grp_if[g])
			);
		end
	endgenerate

	// The sixteenth map sits alone in the last group.
	ifm_group #(
		.num_maps(1)
	) u_group_last
	(
		.clk(clk),
		.rst_n(rst_n),
		.port(grp_if[LAST_GROUP])
	);

endmodule

// File: ifm_bank_router.sv
module ifm_bank_router
	import ifm_buffer_pkg::*;
(
	input sel_t ifm_sel,
	input logic enable_write_previous,
	input logic enable_read_previous,
	input logic enable_read_a_next,
	input logic enable_read_b_next,
	input addr_t address_write_previous,
	input addr_t address_read_previous,
	input addr_t address_read_a_next,
	input addr_t address_read_b_next,
	input lane_data_t data_in_previous,
	output lane_data_t data_out_previous,
	output lane_data_t data_out_a_next,
	output lane_data_t data_out_b_next,
	ifm_group_if.router groups [NUM_GROUPS]
);

	sel_t sel_clamped;
	sel_t writer_group;
	sel_t reader_group;

	lane_data_t grp_rd_a [NUM_GROUPS];
	lane_data_t grp_rd_b [NUM_GROUPS];

	// Codes above the last group select the last group.
	always_comb
	begin
		if (ifm_sel > sel_t'(LAST_GROUP))
		begin
			sel_clamped = sel_t'(LAST_GROUP);
		end
		else
		begin
			sel_clamped = ifm_sel;
		end
	end

	// The next layer reads the group filled in the round before.
	always_comb
	begin
		writer_group = sel_clamped;
		if (sel_clamped == '0)
		begin
			reader_group = sel_t'(LAST_GROUP);
		end
		else
		begin
			reader_group = sel_clamped - sel_t'(1);
		end
	end

	genvar g;

	generate
		for (g = 0; g < NUM_GROUPS; g++)
		begin : g_route
			assign groups[g].wr_data = data_in_previous;

			// Writer and reader are never the same group, so each port has one owner.
			always_comb
			begin
				groups[g].wr_en = 1'b0;
				groups[g].rd_a_en = 1'b0;
				groups[g].rd_b_en = 1'b0;
				groups[g].addr_a = '0;
				groups[g].addr_b = '0;
				if (writer_group == sel_t'(g))
				begin
					groups[g].wr_en = enable_write_previous;
					groups[g].addr_a = address_write_previous;
					groups[g].rd_b_en = enable_read_previous;
					groups[g].addr_b = address_read_previous;
				end
				else if (reader_group == sel_t'(g))
				begin
					groups[g].rd_a_en = enable_read_a_next;
					groups[g].addr_a = address_read_a_next;
					groups[g].rd_b_en = enable_read_b_next;
					groups[g].addr_b = address_read_b_next;
				end
			end

			assign grp_rd_a[g] = groups[g].rd_data_a;
			assign grp_rd_b[g] = groups[g].rd_data_b;
		end
	endgenerate

	// Group 5 already drives zero on lanes 2 and 3.
	always_comb
	begin
		data_out_previous = grp_rd_b[writer_group];
		data_out_a_next = grp_rd_a[reader_group];
		data_out_b_next = grp_rd_b[reader_group];
	end

endmodule

// File: ifm_group.sv
module ifm_group
	import ifm_buffer_pkg::*;
#(
	parameter int num_maps = NUM_LANES
)
(
	input logic clk,
	input logic rst_n,
	ifm_group_if.group port
);

	lane_data_t data_a;
	lane_data_t data_b;

	genvar m;

	generate
		for (m = 0; m < NUM_LANES; m++)
		begin : g_lane
			if (m < num_maps)
			begin : g_map
				// Every map of the group sees the same enables and addresses.
				ifm_map_ram u_ram
				(
					.clk(clk),
					.rst_n(rst_n),
					.wr_en(port.wr_en),
					.rd_a_en(port.rd_a_en),
					.rd_b_en(port.rd_b_en),
					.addr_a(port.addr_a),
					.addr_b(port.addr_b),
					.wr_data(port.wr_data[m]),
					.rd_data_a(data_a[m]),
					.rd_data_b(data_b[m])
				);
			end
			else
			begin : g_empty
				// The write data of this lane is dropped.
				assign data_a[m] = '0;
				assign data_b[m] = '0;
			end
		end
	endgenerate

	assign port.rd_data_a = data_a;
	assign port.rd_data_b = data_b;

endmodule

// File: ifm_map_ram.sv
module ifm_map_ram
	import ifm_buffer_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input logic rd_a_en,
	input logic rd_b_en,
	input addr_t addr_a,
	input addr_t addr_b,
	input data_t wr_data,
	output data_t rd_data_a,
	output data_t rd_data_b
);

	data_t mem [MAP_DEPTH];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[addr_a] <= wr_data;
		end
	end

	// A read in the same cycle as a write to the same word sees the old contents.
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_data_a <= '0;
			rd_data_b <= '0;
		end
		else
		begin
			if (rd_a_en)
			begin
				rd_data_a <= mem[addr_a];
			end
			if (rd_b_en)
			begin
				rd_data_b <= mem[addr_b];
			end
		end
	end

endmodule

// File: ifm_group_if.sv
interface ifm_group_if
	import ifm_buffer_pkg::*;
();

	// Port A carries the writes of the previous layer and the A reads of the next layer.
	logic wr_en;
	logic rd_a_en;
	addr_t addr_a;

	// Port B is read only.
	logic rd_b_en;
	addr_t addr_b;

	lane_data_t wr_data;

	// Lanes that a group lacks read back as zero.
	lane_data_t rd_data_a;
	lane_data_t rd_data_b;

	modport router
	(
		output wr_en,
		output rd_a_en,
		output rd_b_en,
		output addr_a,
		output addr_b,
		output wr_data,
		input rd_data_a,
		input rd_data_b
	);

	modport group
	(
		input wr_en,
		input rd_a_en,
		input rd_b_en,
		input addr_a,
		input addr_b,
		input wr_data,
		output rd_data_a,
		output rd_data_b
	);

endinterface

// File: ifm_buffer_pkg.sv
package ifm_buffer_pkg;

	// A map word and the square map it belongs to.
	localparam int DATA_WIDTH = 32;
	localparam int IFM_SIZE   = 32;
	localparam int MAP_DEPTH  = IFM_SIZE * IFM_SIZE;
	localparam int ADDR_WIDTH = $clog2(MAP_DEPTH);

	// Three maps move in parallel between the layers.
	localparam int NUM_LANES = 3;

	// Five groups of three maps and one group holding the sixteenth map alone.
	localparam int NUM_GROUPS = 6;
	localparam int LAST_GROUP = NUM_GROUPS - 1;
	localparam int SEL_WIDTH  = $clog2(NUM_GROUPS);

	typedef logic [DATA_WIDTH-1:0] data_t;

	typedef logic [ADDR_WIDTH-1:0] addr_t;

	typedef logic [SEL_WIDTH-1:0] sel_t;

	// Lane 1 of the top level is index 0.
	typedef data_t [NUM_LANES-1:0] lane_data_t;

endpackage
